// ==== bus_pkg.sv ====
`default_nettype none

// system bus shared by the matrix refresh and pattern masters
package bus_pkg;

  ////////////////////////////////////////////////////////////
  // field widths
  ////////////////////////////////////////////////////////////

  // 16 bit byte address, one data byte per beat
  localparam int unsigned BUS_ADDR_W = 16;
  localparam int unsigned BUS_DATA_W = 8;
  // cycle type identifier
  localparam int unsigned BUS_CTI_W  = 3;

  typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
  typedef logic [BUS_DATA_W-1:0] bus_data_t;
  typedef logic [BUS_CTI_W-1:0]  bus_cti_t;

  ////////////////////////////////////////////////////////////
  // master request and slave response
  ////////////////////////////////////////////////////////////

  // one master's request, cyc held for the whole transfer
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    // single byte lane
    logic      sel;
    bus_addr_t adr;
    bus_data_t dat;
    bus_cti_t  cti;
  } bus_req_t;

  // one slave's response, dat only meaningful with ack
  typedef struct packed {
    logic      ack;
    bus_data_t dat;
  } bus_rsp_t;

  // driven onto the bus when no master holds cyc
  localparam bus_req_t BUS_IDLE_REQ = '0;

endpackage

`default_nettype wire

// ==== dfu_pkg.sv ====
`default_nettype none

// firmware update, flash pins and audio meter types
package dfu_pkg;

  ////////////////////////////////////////////////////////////
  // dfu states
  ////////////////////////////////////////////////////////////

  // standard dfu class state codes, as reported by the usb core
  typedef enum logic [7:0] {
    DFU_APP_IDLE            = 8'h00,
    DFU_APP_DETACH          = 8'h01,
    DFU_IDLE                = 8'h02,
    DFU_DNLOAD_SYNC         = 8'h03,
    DFU_DNBUSY              = 8'h04,
    DFU_DNLOAD_IDLE         = 8'h05,
    DFU_MANIFEST_SYNC       = 8'h06,
    DFU_MANIFEST            = 8'h07,
    DFU_MANIFEST_WAIT_RESET = 8'h08,
    DFU_UPLOAD_IDLE         = 8'h09,
    DFU_ERROR               = 8'h0a
  } dfu_state_e;

  ////////////////////////////////////////////////////////////
  // spi master outputs
  ////////////////////////////////////////////////////////////

  // d_dir bit set means that data line is driven
  typedef struct packed {
    logic       sck;
    logic       cs;
    logic [3:0] d_out;
    logic [3:0] d_dir;
  } spi_pins_t;

  ////////////////////////////////////////////////////////////
  // volume meter
  ////////////////////////////////////////////////////////////

  // two's complement mic sample
  typedef logic signed [11:0] sample_t;
  // wide enough for the magnitude of negative full scale
  typedef logic [11:0]        magnitude_t;
  // 0 is silent, 10 is full deflection
  typedef logic [3:0]         volume_level_t;

  localparam volume_level_t VOLUME_LEVEL_MAX = 4'd10;

endpackage

`default_nettype wire

// ==== bus_arbiter.sv ====
`default_nettype none

// fixed priority arbiter for the two bus masters
// matrix refresh (m0) wins over the pattern generator (m1)
module bus_arbiter import bus_pkg::*; (
  // matrix refresh master
  input  bus_req_t m0_req_i,
  // pattern generator master
  input  bus_req_t m1_req_i,
  // matrix register block
  input  bus_rsp_t mat_rsp_i,
  // frame memory
  input  bus_rsp_t mem_rsp_i,

  output bus_req_t bus_o,
  output bus_rsp_t rsp_o,
  output logic     m0_block_o,
  output logic     m1_block_o
);

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////

  // grant follows cyc directly, no grant register
  // a master keeps the bus for as long as it holds cyc
  always_comb begin
    if (m0_req_i.cyc) begin
      bus_o = m0_req_i;
    end else if (m1_req_i.cyc) begin
      bus_o = m1_req_i;
    end else begin
      // nobody on the bus
      bus_o = BUS_IDLE_REQ;
    end
  end

  // each master waits while the other one holds cyc
  assign m0_block_o = m1_req_i.cyc;
  assign m1_block_o = m0_req_i.cyc;

  ////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////

  // both masters see the same merged response
  always_comb begin
    // either slave finishing ends the beat
    rsp_o.ack = mat_rsp_i.ack | mem_rsp_i.ack;

    // register block first, then frame memory
    if (mat_rsp_i.ack) begin
      rsp_o.dat = mat_rsp_i.dat;
    end else if (mem_rsp_i.ack) begin
      rsp_o.dat = mem_rsp_i.dat;
    end else begin
      // quiet data when no slave answers
      rsp_o.dat = '0;
    end
  end

endmodule

`default_nettype wire

// ==== dfu_flash_ctrl.sv ====
`default_nettype none

// spi flash sharing between the dfu engine and the frame memory
// controller, plus the warm-boot request after a usb bus reset
module dfu_flash_ctrl import dfu_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,

  // dfu engine
  input  dfu_state_e dfu_state_i,
  input  logic       usb_reset_i,
  input  spi_pins_t  dfu_spi_i,
  output logic       dfu_miso_o,

  // frame memory controller
  input  logic       mem_busy_i,
  input  spi_pins_t  mem_spi_i,
  output logic [3:0] mem_d_o,

  // flash device
  input  logic [3:0] flash_d_i,
  output spi_pins_t  flash_spi_o,

  output logic       flash_busy_o,
  output logic       usb_to_flash_o,
  output logic       flash_to_usb_o,
  output logic       boot_req_o
);

  // dfu engine owns the flash
  logic dfu_busy;
  // bus reset seen on the previous clock
  logic usb_reset_q;

  ////////////////////////////////////////////////////////////
  // state decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    // anything outside the idle states takes the flash
    dfu_busy       = 1'b1;
    usb_to_flash_o = 1'b0;
    flash_to_usb_o = 1'b0;
    case (dfu_state_i)
      DFU_APP_IDLE, DFU_APP_DETACH, DFU_IDLE: begin
        dfu_busy = 1'b0;
      end
      // download writes the flash
      DFU_DNLOAD_SYNC, DFU_DNBUSY, DFU_DNLOAD_IDLE: begin
        usb_to_flash_o = 1'b1;
      end
      // upload reads it back
      DFU_UPLOAD_IDLE: begin
        flash_to_usb_o = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign flash_busy_o = mem_busy_i | dfu_busy;

  ////////////////////////////////////////////////////////////
  // pin routing
  ////////////////////////////////////////////////////////////

  always_comb begin
    if (dfu_busy) begin
      flash_spi_o.sck   = dfu_spi_i.sck;
      flash_spi_o.cs    = dfu_spi_i.cs;
      // plain single-line spi, mosi on d0 and miso on d1
      flash_spi_o.d_out = {3'b000, dfu_spi_i.d_out[0]};
      flash_spi_o.d_dir = 4'b0001;
      dfu_miso_o        = flash_d_i[1];
      // memory side reads nothing meanwhile
      mem_d_o           = '0;
    end else begin
      // memory controller may run quad mode
      flash_spi_o = mem_spi_i;
      mem_d_o     = flash_d_i;
      dfu_miso_o  = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // warm boot
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      usb_reset_q <= 1'b0;
    end else begin
      usb_reset_q <= usb_reset_i;
    end
  end

  // host reset while detach is pending restarts into the bootloader
  assign boot_req_o = usb_reset_q && (dfu_state_i == DFU_APP_DETACH);

endmodule

`default_nettype wire

// ==== volume_meter.sv ====
`default_nettype none

// peak-hold volume meter
// peak magnitude of the valid samples over a fixed window,
// mapped to a 0..10 level at every window end
module volume_meter import dfu_pkg::*; #(
  // window length in clocks
  parameter int unsigned WINDOW_CYCLES = 60000
) (
  input  logic          clk,
  input  logic          rst_n_i,
  input  sample_t       sample_i,
  input  logic          sample_valid_i,
  output volume_level_t volume_o
);

  localparam int unsigned CNT_W = (WINDOW_CYCLES > 1) ? $clog2(WINDOW_CYCLES) : 1;
  // count of the last clock in a window
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WINDOW_CYCLES - 1);

  logic [CNT_W-1:0] win_cnt;
  logic             win_end;
  magnitude_t       sample_mag;
  // sample magnitude, zero when not valid
  magnitude_t       cand_mag;
  magnitude_t       peak_q;
  // peak including this clock's sample
  magnitude_t       window_max;

  ////////////////////////////////////////////////////////////
  // level mapping
  ////////////////////////////////////////////////////////////

  // roughly logarithmic, by highest set bit
  function automatic volume_level_t level_of(input magnitude_t mag);
    volume_level_t lvl;
    if (mag[11] || mag[10]) begin
      lvl = VOLUME_LEVEL_MAX;
    end else if (mag[9]) begin
      lvl = 4'd8;
    end else if (mag[8]) begin
      lvl = 4'd6;
    end else if (mag[7]) begin
      lvl = 4'd4;
    end else if (mag[6]) begin
      lvl = 4'd3;
    end else if (mag[5]) begin
      lvl = 4'd2;
    end else if (mag[4]) begin
      lvl = 4'd1;
    end else begin
      // below 16 counts is treated as silence
      lvl = 4'd0;
    end
    return lvl;
  endfunction

  ////////////////////////////////////////////////////////////
  // peak hold
  ////////////////////////////////////////////////////////////

  // -2048 gives 2048, still fits in 12 unsigned bits
  assign sample_mag = sample_i[11] ? magnitude_t'(-sample_i) : magnitude_t'(sample_i);
  assign cand_mag   = sample_valid_i ? sample_mag : '0;
  assign window_max = (cand_mag > peak_q) ? cand_mag : peak_q;
  assign win_end    = (win_cnt == CNT_LAST);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      win_cnt  <= '0;
      peak_q   <= '0;
      volume_o <= '0;
    end else if (win_end) begin
      // publish this window, start the next one empty
      win_cnt  <= '0;
      peak_q   <= '0;
      volume_o <= level_of(window_max);
    end else begin
      win_cnt  <= win_cnt + 1'b1;
      peak_q   <= window_max;
    end
  end

endmodule

`default_nettype wire

// ==== badge_ctrl_top.sv ====
`default_nettype none

// badge controller glue
// bus arbitration, flash sharing with warm boot, volume meter
module badge_ctrl_top import bus_pkg::*, dfu_pkg::*; #(
  // 12 MHz / 200
  parameter int unsigned WINDOW_CYCLES = 60000
) (
  input  logic          clk,
  input  logic          rst_n_i,

  // system bus masters and slaves
  input  bus_req_t      m0_req_i,
  input  bus_req_t      m1_req_i,
  input  bus_rsp_t      mat_rsp_i,
  input  bus_rsp_t      mem_rsp_i,
  output bus_req_t      bus_o,
  output bus_rsp_t      rsp_o,
  output logic          m0_block_o,
  output logic          m1_block_o,

  // dfu engine and flash
  input  dfu_state_e    dfu_state_i,
  input  logic          usb_reset_i,
  input  logic          mem_busy_i,
  input  spi_pins_t     dfu_spi_i,
  input  spi_pins_t     mem_spi_i,
  input  logic [3:0]    flash_d_i,
  output spi_pins_t     flash_spi_o,
  output logic          dfu_miso_o,
  output logic [3:0]    mem_d_o,
  output logic          flash_busy_o,
  output logic          usb_to_flash_o,
  output logic          flash_to_usb_o,
  output logic          boot_req_o,

  // microphone
  input  sample_t       sample_i,
  input  logic          sample_valid_i,
  output volume_level_t volume_o
);

  ////////////////////////////////////////////////////////////
  // system bus
  ////////////////////////////////////////////////////////////

  bus_arbiter u_bus_arbiter (
    .m0_req_i   (m0_req_i),
    .m1_req_i   (m1_req_i),
    .mat_rsp_i  (mat_rsp_i),
    .mem_rsp_i  (mem_rsp_i),
    .bus_o      (bus_o),
    .rsp_o      (rsp_o),
    .m0_block_o (m0_block_o),
    .m1_block_o (m1_block_o)
  );

  ////////////////////////////////////////////////////////////
  // flash ownership
  ////////////////////////////////////////////////////////////

  dfu_flash_ctrl u_dfu_flash_ctrl (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .dfu_state_i    (dfu_state_i),
    .usb_reset_i    (usb_reset_i),
    .dfu_spi_i      (dfu_spi_i),
    .dfu_miso_o     (dfu_miso_o),
    .mem_busy_i     (mem_busy_i),
    .mem_spi_i      (mem_spi_i),
    .mem_d_o        (mem_d_o),
    .flash_d_i      (flash_d_i),
    .flash_spi_o    (flash_spi_o),
    .flash_busy_o   (flash_busy_o),
    .usb_to_flash_o (usb_to_flash_o),
    .flash_to_usb_o (flash_to_usb_o),
    .boot_req_o     (boot_req_o)
  );

  // volume level for the pattern generator
  volume_meter #(
    .WINDOW_CYCLES (WINDOW_CYCLES)
  ) u_volume_meter (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .sample_i       (sample_i),
    .sample_valid_i (sample_valid_i),
    .volume_o       (volume_o)
  );

endmodule

`default_nettype wire

// ==== tb_badge_checks.svh ====
`ifndef TB_BADGE_CHECKS_SVH
`define TB_BADGE_CHECKS_SVH

// lfsr state, stepped once per stimulus bit
logic [31:0] lfsr_q;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// n fresh bits, newest in the lsb
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_q = lfsr_step(lfsr_q);
    r = {r[30:0], lfsr_q[0]};
  end
  return r;
endfunction

////////////////////////////////////////////////////////////
// compare tasks, one per result type
////////////////////////////////////////////////////////////

task automatic check_bus_req(input string name, input bus_req_t got, input bus_req_t exp);
  if (got !== exp) begin
    $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    stop_on_failure();
  end
  checks_done++;
endtask

task automatic check_bus_rsp(input string name, input bus_rsp_t got, input bus_rsp_t exp);
  if (got !== exp) begin
    $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    stop_on_failure();
  end
  checks_done++;
endtask

task automatic check_spi(input string name, input spi_pins_t got, input spi_pins_t exp);
  if (got !== exp) begin
    $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    stop_on_failure();
  end
  checks_done++;
endtask

task automatic check_level(input string name, input volume_level_t got,
                           input volume_level_t exp);
  if (got !== exp) begin
    $display("FAILED at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    stop_on_failure();
  end
  checks_done++;
endtask

// 4 bit flash data lines
task automatic check_data_in(input string name, input logic [3:0] got, input logic [3:0] exp);
  if (got !== exp) begin
    $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
    stop_on_failure();
  end
  checks_done++;
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
    stop_on_failure();
  end
  checks_done++;
endtask

`endif

// ==== tb_badge_ctrl.sv ====
`default_nettype none

// badge controller glue driven by stimulus and expected values from a pattern file
module tb_badge_ctrl import bus_pkg::*, dfu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WINDOW     = 16;
  localparam int WAIT_LIMIT = 4 * WINDOW;

  logic          clk;
  logic          rst_n_i;
  bus_req_t      m0_req_i;
  bus_req_t      m1_req_i;
  bus_rsp_t      mat_rsp_i;
  bus_rsp_t      mem_rsp_i;
  bus_req_t      bus_o;
  bus_rsp_t      rsp_o;
  logic          m0_block_o;
  logic          m1_block_o;
  dfu_state_e    dfu_state_i;
  logic          usb_reset_i;
  logic          mem_busy_i;
  spi_pins_t     dfu_spi_i;
  spi_pins_t     mem_spi_i;
  logic [3:0]    flash_d_i;
  spi_pins_t     flash_spi_o;
  logic          dfu_miso_o;
  logic [3:0]    mem_d_o;
  logic          flash_busy_o;
  logic          usb_to_flash_o;
  logic          flash_to_usb_o;
  logic          boot_req_o;
  sample_t       sample_i;
  logic          sample_valid_i;
  volume_level_t volume_o;

  // rising edges since reset release
  int          edge_cnt;
  int          checks_done;
  // fields of the current pattern line
  logic [31:0] fld [0:8];

  badge_ctrl_top #(.WINDOW_CYCLES(WINDOW)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  `include "tb_badge_checks.svh"

  task automatic advance_clock();
    @(posedge clk);
    edge_cnt++;
  endtask

  task automatic bad_line(input string line);
    $display("malformed pattern line: %s", line);
    stop_on_failure();
  endtask

  ////////////////////////////////////////////////////////////
  // one task per record kind that starts on a rising edge
  ////////////////////////////////////////////////////////////

  task automatic arbitrate_masters();
    bus_req_t r0;
    bus_req_t r1;
    bus_req_t exp_bus;
    // only cyc comes from the line
    r0 = bus_req_t'(rand_bits($bits(bus_req_t) - 1));
    r0.cyc = fld[0][0];
    r1 = bus_req_t'(rand_bits($bits(bus_req_t) - 1));
    r1.cyc = fld[1][0];
    m0_req_i  <= r0;
    m1_req_i  <= r1;
    mat_rsp_i <= {fld[2][0], fld[3][7:0]};
    mem_rsp_i <= {fld[4][0], fld[5][7:0]};
    case (fld[6])
      0: exp_bus = r0;
      1: exp_bus = r1;
      default: exp_bus = BUS_IDLE_REQ;
    endcase
    @(negedge clk);
    check_bus_req("bus_o", bus_o, exp_bus);
    check_bus_rsp("rsp_o", rsp_o, {fld[7][0], fld[8][7:0]});
    // each master is held off by the other's cyc
    check_flag("m0_block_o", m0_block_o, r1.cyc);
    check_flag("m1_block_o", m1_block_o, r0.cyc);
    advance_clock();
  endtask

  task automatic route_flash_pins();
    spi_pins_t ds;
    spi_pins_t ms;
    spi_pins_t exp_pins;
    logic      own;
    ds  = spi_pins_t'(rand_bits($bits(spi_pins_t)));
    ms  = spi_pins_t'(rand_bits($bits(spi_pins_t)));
    own = fld[3][0];
    dfu_state_i <= dfu_state_e'(fld[0][7:0]);
    flash_d_i   <= fld[1][3:0];
    mem_busy_i  <= fld[2][0];
    dfu_spi_i   <= ds;
    mem_spi_i   <= ms;
    // dfu side is plain spi with mosi on d0 only
    exp_pins = own ? {ds.sck, ds.cs, 3'b000, ds.d_out[0], 4'b0001} : ms;
    @(negedge clk);
    check_spi("flash_spi_o", flash_spi_o, exp_pins);
    // miso comes back on d1
    check_flag("dfu_miso_o", dfu_miso_o, own & fld[1][1]);
    check_data_in("mem_d_o", mem_d_o, own ? 4'h0 : fld[1][3:0]);
    check_flag("flash_busy_o", flash_busy_o, fld[4][0]);
    check_flag("usb_to_flash_o", usb_to_flash_o, fld[5][0]);
    check_flag("flash_to_usb_o", flash_to_usb_o, fld[6][0]);
    advance_clock();
  endtask

  task automatic pulse_usb_reset();
    dfu_state_i <= dfu_state_e'(fld[0][7:0]);
    usb_reset_i <= fld[1][0];
    @(negedge clk);
    check_flag("boot_req_o", boot_req_o, 1'b0);
    advance_clock();
    usb_reset_i <= 1'b0;
    // request one cycle after the bus reset
    @(negedge clk);
    check_flag("boot_req_o", boot_req_o, fld[2][0]);
    advance_clock();
    @(negedge clk);
    check_flag("boot_req_o", boot_req_o, 1'b0);
    advance_clock();
  endtask

  task automatic measure_window();
    sample_t peak;
    int      pos;
    int      waited;
    peak   = fld[1][11:0];
    pos    = int'(fld[2]);
    waited = 0;
    // align to a window start
    while (edge_cnt % WINDOW != 0) begin
      advance_clock();
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("timeout: no volume window started within %0d clocks", WAIT_LIMIT);
        stop_on_failure();
      end
    end
    for (int k = 0; k < WINDOW; k++) begin
      if (k == pos) begin
        sample_i       <= peak;
        sample_valid_i <= 1'b1;
      end else if (k == (pos + 9) % WINDOW) begin
        // smaller valid sample of the same sign
        sample_i       <= peak >>> 1;
        sample_valid_i <= 1'b1;
      end else if (k == (pos + 5) % WINDOW) begin
        // large sample without valid
        sample_i       <= fld[3][11:0];
        sample_valid_i <= 1'b0;
      end else begin
        sample_i       <= sample_t'(rand_bits(12));
        sample_valid_i <= 1'b0;
      end
      // previous window was idle so level stays 0 until this window ends
      if (k == 0 || k == WINDOW - 1) begin
        @(negedge clk);
        check_level("volume_o", volume_o, '0);
      end
      advance_clock();
    end
    // next window stays idle
    sample_valid_i <= 1'b0;
    @(negedge clk);
    check_level("volume_o", volume_o, volume_level_t'(fld[0]));
    advance_clock();
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    string line;
    int    fd;
    int    n;
    byte   kind;
    rst_n_i        = 1'b0;
    m0_req_i       = BUS_IDLE_REQ;
    m1_req_i       = BUS_IDLE_REQ;
    mat_rsp_i      = '0;
    mem_rsp_i      = '0;
    dfu_state_i    = DFU_APP_IDLE;
    usb_reset_i    = 1'b0;
    mem_busy_i     = 1'b0;
    dfu_spi_i      = '0;
    mem_spi_i      = '0;
    flash_d_i      = '0;
    sample_i       = '0;
    sample_valid_i = 1'b0;
    lfsr_q         = 32'h8a5d;
    edge_cnt       = 0;
    checks_done    = 0;
    fd = $fopen("badge_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open badge_patterns.txt");
      stop_on_failure();
    end
    // three clocks in reset
    @(posedge clk);
    @(posedge clk);
    @(negedge clk);
    check_flag("boot_req_o", boot_req_o, 1'b0);
    check_level("volume_o", volume_o, '0);
    @(posedge clk);
    rst_n_i <= 1'b1;
    edge_cnt = 0;
    while ($fgets(line, fd) != 0) begin
      kind = line.getc(0);
      case (kind)
        "A": begin
          n = $sscanf(line, "A %h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                      fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
          if (n != 9) bad_line(line);
          arbitrate_masters();
        end
        "D": begin
          n = $sscanf(line, "D %h %h %h %h %h %h %h", fld[0], fld[1], fld[2], fld[3],
                      fld[4], fld[5], fld[6]);
          if (n != 7) bad_line(line);
          route_flash_pins();
        end
        "S": begin
          n = $sscanf(line, "S %h %h %h %h", fld[0], fld[1], fld[2], fld[3]);
          if (n != 4) bad_line(line);
          measure_window();
        end
        "B": begin
          n = $sscanf(line, "B %h %h %h", fld[0], fld[1], fld[2]);
          if (n != 3) bad_line(line);
          pulse_usb_reset();
        end
        // comments and blank lines
        "#", "\n", "\r", " ": begin
        end
        default: bad_line(line);
      endcase
    end
    $fclose(fd);
    if (checks_done > 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("no checks ran because the pattern file held no records");
      stop_on_failure();
    end
  end

endmodule

`default_nettype wire

// ==== badge_patterns.txt ====
# A: m0_cyc m1_cyc mat_ack mat_dat mem_ack mem_dat grant(0 m0, 1 m1, 2 idle) ack dat
# D: state flash_d mem_busy dfu_owns busy usb_to_flash flash_to_usb   B: state pulse boot
# S: level peak_sample peak_slot invalid_sample   (all values hex)
A 1 1 1 3c 1 a5 0 1 3c
A 1 0 0 11 1 5a 0 1 5a
A 0 1 1 c3 0 77 1 1 c3
A 0 0 0 e1 0 2d 2 0 00
A 0 1 0 44 1 99 1 1 99
A 1 0 0 ff 0 ee 0 0 00
A 0 0 1 81 1 18 2 1 81
D 00 a 1 0 1 0 0
D 01 5 0 0 0 0 0
D 02 f 0 0 0 0 0
D 03 6 0 1 1 1 0
D 04 9 0 1 1 1 0
D 05 3 1 1 1 1 0
D 06 c 0 1 1 0 0
D 07 2 0 1 1 0 0
D 08 d 0 1 1 0 0
D 09 e 0 1 1 0 1
D 0a 1 0 1 1 0 0
D 02 7 1 0 1 0 0
B 01 1 1
B 02 1 0
B 01 0 0
S 0 000 3 800
S 1 014 0 7ff
S 3 fba 7 800
S 6 12c c 3e8
S 8 3e8 f 7ff
S a 7ff 5 800
S a 800 a 001

// ==== project.f ====
+incdir+.
bus_pkg.sv
dfu_pkg.sv
bus_arbiter.sv
dfu_flash_ctrl.sv
volume_meter.sv
badge_ctrl_top.sv
tb_badge_ctrl.sv

// ==== Bender.yml ====
package:
  name: badge_ctrl

sources:
  - bus_pkg.sv
  - dfu_pkg.sv
  - bus_arbiter.sv
  - dfu_flash_ctrl.sv
  - volume_meter.sv
  - badge_ctrl_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_badge_ctrl.sv
